// ==== bench/contrast_model.svh ====
`ifndef CONTRAST_MODEL_SVH
`define CONTRAST_MODEL_SVH

localparam int HIST_DEPTH = 4096;
localparam int M_ROW_LEN  = contrast_cfg_pkg::ROW_LEN_DEFAULT;
localparam int M_ROWS     = contrast_cfg_pkg::WINDOW_ROWS;
localparam int M_LATENCY  = contrast_cfg_pkg::TREE_STAGES + 1;

contrast_types_pkg::pixel_t pix_hist [HIST_DEPTH];
logic done_hist [HIST_DEPTH]; // done level seen by the first line buffer.
logic run_hist  [HIST_DEPTH]; // rst_n high in that cycle.
int   hist_base;              // first cycle after the latest reset.
int   last_pulse;

task automatic model_clear();
  for (int i = 0; i < HIST_DEPTH; i++) begin
    pix_hist[i]  = '0;
    done_hist[i] = 1'b0;
    run_hist[i]  = 1'b0;
  end
  hist_base  = 0;
  last_pulse = -HIST_DEPTH;
endtask

task automatic model_record(input int c, input contrast_types_pkg::pixel_t p,
                            input logic d, input logic run);
  if (!run) begin
    pix_hist[c]  = '0;
    done_hist[c] = 1'b0;
    run_hist[c]  = 1'b0;
    hist_base    = c + 1; // history restarts from zeros.
    last_pulse   = -HIST_DEPTH;
  end else begin
    if (d) begin
      last_pulse = c;
    end
    pix_hist[c]  = p;
    done_hist[c] = (c - last_pulse) <= M_ROW_LEN; // pulse plus one stretched row.
    run_hist[c]  = 1'b1;
  end
endtask

function automatic contrast_types_pkg::pixel_t pix_at(input int i);
  if (i < hist_base) begin
    return '0;
  end
  return pix_hist[i];
endfunction

function automatic logic done_at(input int i);
  if (i < hist_base) begin
    return 1'b0;
  end
  return done_hist[i];
endfunction

// any reset edge while the column is in the pipe zeroes the result.
function automatic logic pipe_clear(input int c);
  for (int j = c - M_LATENCY; j < c; j++) begin
    if (j < 0 || !run_hist[j]) begin
      return 1'b1;
    end
  end
  return 1'b0;
endfunction

function automatic contrast_types_pkg::range_t expected_range(input int c);
  int t;
  contrast_types_pkg::pixel_t hi;
  contrast_types_pkg::pixel_t lo;
  contrast_types_pkg::pixel_t v;
  if (pipe_clear(c)) begin
    return '0;
  end
  t  = c - M_LATENCY;
  hi = '0;
  lo = '1;
  for (int k = 0; k < M_ROWS; k++) begin
    v = pix_at(t - k * M_ROW_LEN);
    if (v > hi) hi = v;
    if (v < lo) lo = v;
  end
  return hi - lo;
endfunction

function automatic logic expected_done(input int c);
  if (pipe_clear(c)) begin
    return 1'b0;
  end
  return done_at(c - M_LATENCY - (M_ROWS - 1) * M_ROW_LEN);
endfunction

`endif

// ==== bench/contrast_tb.sv ====
`timescale 1ns/100ps

module contrast_tb;

  localparam int ROW_LEN      = contrast_cfg_pkg::ROW_LEN_DEFAULT;
  localparam int THRESHOLD    = contrast_cfg_pkg::THRESHOLD_DEFAULT;
  localparam int FRAMES       = 3;
  localparam int FRAME_ROWS   = 14;
  localparam int RESET_CYCLES = 10;
  localparam int BURST_PULSES = 5;
  localparam int BURST_GAP    = 7;  // well inside one stretched window.
  localparam int HIGH_TIMEOUT = 13 * ROW_LEN + 10;
  localparam int LOW_TIMEOUT  = (BURST_PULSES + 2) * ROW_LEN;

  logic                       clk;
  logic                       rst_n;
  contrast_types_pkg::pixel_t pix_i;
  logic                       done_i;
  contrast_types_pkg::range_t range_o;
  logic                       edge_o;
  logic                       done_o;

  logic [31:0] rng_state;
  int          cyc;
  int          edge_hi_cnt;
  int          edge_lo_cnt;

  `include "contrast_model.svh"

  contrast_top #(
    .ROW_LEN   (ROW_LEN),
    .THRESHOLD (THRESHOLD)
  ) i_contrast_top (
    .clk     (clk),
    .rst_n   (rst_n),
    .pix_i   (pix_i),
    .done_i  (done_i),
    .range_o (range_o),
    .edge_o  (edge_o),
    .done_o  (done_o)
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // narrow rows stay in a band below the threshold, spikes of 0 and 255 aside.
  task automatic draw_pixel(input bit narrow, output contrast_types_pkg::pixel_t p);
    rng_state = xorshift32(rng_state);
    if (rng_state[31:27] == 5'd0) begin
      p = 8'd0;
    end else if (rng_state[31:27] == 5'd1) begin
      p = 8'd255;
    end else if (narrow) begin
      p = 8'd112 + {3'b000, rng_state[4:0]};
    end else begin
      p = rng_state[7:0];
    end
  endtask

  task automatic fail_stop();
    $display("Errors found");
    $fatal(1, "simulation stopped on first failure");
  endtask

  task automatic check_range(input string name, input contrast_types_pkg::range_t exp,
                             input contrast_types_pkg::range_t act);
    if (act !== exp) begin
      $display("[ERROR] %s at cycle %0d: expected %0d, actual %0d", name, cyc, exp, act);
      fail_stop();
    end
  endtask

  task automatic check_edge(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[ERROR] %s at cycle %0d: expected %b, actual %b", name, cyc, exp, act);
      fail_stop();
    end
  endtask

  task automatic check_done(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[ERROR] %s at cycle %0d: expected %b, actual %b", name, cyc, exp, act);
      fail_stop();
    end
  endtask

  // checks the outputs of the previous edge, then drives this cycle.
  task automatic run_cycle(input string test, input contrast_types_pkg::pixel_t p,
                           input logic d, input logic run);
    contrast_types_pkg::range_t exp_range;
    logic                       exp_edge;
    @(negedge clk);
    exp_range = expected_range(cyc);
    exp_edge  = int'(exp_range) > THRESHOLD;
    check_range({test, " range"}, exp_range, range_o);
    check_edge({test, " edge"}, exp_edge, edge_o);
    check_done({test, " done"}, expected_done(cyc), done_o);
    if (!pipe_clear(cyc)) begin
      if (exp_edge) edge_hi_cnt++;
      else edge_lo_cnt++;
    end
    rst_n  = run;
    pix_i  = p;
    done_i = d;
    model_record(cyc, p, d, run);
    cyc++;
  endtask

  initial begin
    contrast_types_pkg::pixel_t p;
    logic                       last;
    int                         waited;
    clk         = 1'b0;
    rst_n       = 1'b0;
    pix_i       = '0;
    done_i      = 1'b0;
    rng_state   = 32'd3;
    cyc         = 0;
    edge_hi_cnt = 0;
    edge_lo_cnt = 0;
    model_clear();

    for (int i = 0; i < RESET_CYCLES; i++) begin
      run_cycle("reset", '0, 1'b0, 1'b0);
    end
    for (int i = 0; i < 8; i++) begin
      run_cycle("idle after reset", '0, 1'b0, 1'b1); // all outputs still zero.
    end

    for (int f = 0; f < FRAMES; f++) begin
      for (int r = 0; r < FRAME_ROWS; r++) begin
        for (int x = 0; x < ROW_LEN; x++) begin
          // past the previous frame's done window.
          if (f == FRAMES - 1 && r == FRAME_ROWS - 1 && x == 9) begin
            for (int k = 0; k < RESET_CYCLES; k++) begin
              run_cycle("mid-stream reset", '0, 1'b0, 1'b0);
            end
          end
          draw_pixel(f != 0, p);
          last = (r == FRAME_ROWS - 1) && (x == ROW_LEN - 1);
          run_cycle($sformatf("frame %0d", f), p, last, 1'b1);
        end
      end
    end

    // done pulses closer together than one stretched window.
    for (int b = 0; b < BURST_PULSES; b++) begin
      for (int x = 0; x < BURST_GAP; x++) begin
        draw_pixel(1'b1, p);
        run_cycle("close done pulses", p, x == BURST_GAP - 1, 1'b1);
      end
    end

    waited = 0;
    while (done_o !== 1'b1) begin
      if (waited == HIGH_TIMEOUT) begin
        $display("timeout: done_o never went high after the last frame");
        fail_stop();
      end else begin
        draw_pixel(1'b1, p);
        run_cycle("drain", p, 1'b0, 1'b1);
        waited++;
      end
    end

    waited = 0;
    while (done_o !== 1'b0) begin
      if (waited == LOW_TIMEOUT) begin
        $display("timeout: done_o stayed high after the last done window");
        fail_stop();
      end else begin
        draw_pixel(1'b1, p);
        run_cycle("drain", p, 1'b0, 1'b1);
        waited++;
      end
    end

    for (int i = 0; i < ROW_LEN; i++) begin
      draw_pixel(1'b1, p);
      run_cycle("tail", p, 1'b0, 1'b1);
    end

    if (edge_hi_cnt == 0 || edge_lo_cnt == 0) begin
      $display("stimulus did not produce both edge outcomes");
      $display("Errors found");
      $fatal(1, "edge outcomes incomplete");
    end else begin
      $display("No errors");
      $finish;
    end
  end

endmodule

// ==== common/contrast_cfg_pkg.sv ====
package contrast_cfg_pkg;

  // pixels per image row.
  localparam int ROW_LEN_DEFAULT = 17;

  // current row plus the twelve rows above it.
  localparam int WINDOW_ROWS = 13;

  // register levels that narrow a column from 13 down to 1.
  localparam int TREE_STAGES = 4;

  // edge flagged when the vertical range is above this.
  localparam int THRESHOLD_DEFAULT = 40;

  // width of the done stretch counter.
  localparam int STRETCH_CNT_W = 10;

endpackage

// ==== common/contrast_types_pkg.sv ====
package contrast_types_pkg;

  localparam int PIX_W = 8;

  // one gray level.
  typedef logic [PIX_W-1:0] pixel_t;

  // difference of two gray levels.
  typedef logic [PIX_W-1:0] range_t;

  // vertical column with the current row at index 0 and the oldest on top.
  typedef pixel_t [contrast_cfg_pkg::WINDOW_ROWS-1:0] column_t;

  // tree result with the frame done marker riding along.
  typedef struct packed {
    pixel_t value;
    logic   done;
  } extreme_t;

endpackage

// ==== filelist.f ====
+incdir+bench
common/contrast_cfg_pkg.sv
common/contrast_types_pkg.sv
row_window/line_buffer.sv
row_window/row_window.sv
hdl/column_extreme.sv
hdl/range_combiner.sv
hdl/contrast_top.sv
bench/contrast_tb.sv

// ==== hdl/column_extreme.sv ====
`timescale 1ns/100ps

module column_extreme #(
  parameter bit FIND_MAX = 1'b1
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  contrast_types_pkg::column_t  column_i,
  input  logic                         done_i,
  output contrast_types_pkg::extreme_t result_o
);

  localparam int N0     = contrast_cfg_pkg::WINDOW_ROWS;
  localparam int N1     = (N0 + 1) / 2;
  localparam int N2     = (N1 + 1) / 2;
  localparam int N3     = (N2 + 1) / 2;
  localparam int N4     = (N3 + 1) / 2;
  localparam int STAGES = contrast_cfg_pkg::TREE_STAGES;

  contrast_types_pkg::pixel_t [N1-1:0] lvl1_q;
  contrast_types_pkg::pixel_t [N2-1:0] lvl2_q;
  contrast_types_pkg::pixel_t [N3-1:0] lvl3_q;
  contrast_types_pkg::pixel_t [N4-1:0] lvl4_q;
  logic [STAGES-1:0]                   done_sr;

  function automatic contrast_types_pkg::pixel_t pick(
    input contrast_types_pkg::pixel_t a,
    input contrast_types_pkg::pixel_t b
  );
    if (FIND_MAX) begin
      return (a > b) ? a : b;
    end
    return (a < b) ? a : b;
  endfunction

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      lvl1_q  <= '0;
      lvl2_q  <= '0;
      lvl3_q  <= '0;
      lvl4_q  <= '0;
      done_sr <= '0;
    end else begin
      // level 1 narrows 13 to 7.
      for (int i = 0; i < N0 / 2; i++) begin
        lvl1_q[i] <= pick(column_i[2*i], column_i[2*i+1]);
      end
      if (N0 % 2 != 0) begin
        lvl1_q[N1-1] <= column_i[N0-1]; // odd one passes through.
      end

      // level 2 narrows 7 to 4.
      for (int i = 0; i < N1 / 2; i++) begin
        lvl2_q[i] <= pick(lvl1_q[2*i], lvl1_q[2*i+1]);
      end
      if (N1 % 2 != 0) begin
        lvl2_q[N2-1] <= lvl1_q[N1-1];
      end

      // level 3 narrows 4 to 2.
      for (int i = 0; i < N2 / 2; i++) begin
        lvl3_q[i] <= pick(lvl2_q[2*i], lvl2_q[2*i+1]);
      end
      if (N2 % 2 != 0) begin
        lvl3_q[N3-1] <= lvl2_q[N2-1];
      end

      // level 4 narrows 2 to 1.
      for (int i = 0; i < N3 / 2; i++) begin
        lvl4_q[i] <= pick(lvl3_q[2*i], lvl3_q[2*i+1]);
      end
      if (N3 % 2 != 0) begin
        lvl4_q[N4-1] <= lvl3_q[N3-1];
      end

      done_sr <= {done_sr[STAGES-2:0], done_i}; // in step with the levels.
    end
  end

  assign result_o.value = lvl4_q[0];
  assign result_o.done  = done_sr[STAGES-1];

endmodule

// ==== hdl/contrast_top.sv ====
`timescale 1ns/100ps

module contrast_top #(
  parameter int ROW_LEN   = contrast_cfg_pkg::ROW_LEN_DEFAULT,
  parameter int THRESHOLD = contrast_cfg_pkg::THRESHOLD_DEFAULT
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  contrast_types_pkg::pixel_t pix_i,
  input  logic                       done_i,
  output contrast_types_pkg::range_t range_o,
  output logic                       edge_o,
  output logic                       done_o
);

  contrast_types_pkg::column_t  column;
  logic                         win_done;
  contrast_types_pkg::extreme_t max_res;
  contrast_types_pkg::extreme_t min_res;

  row_window #(
    .ROW_LEN (ROW_LEN)
  ) i_row_window (
    .clk      (clk),
    .rst_n    (rst_n),
    .pix_i    (pix_i),
    .done_i   (done_i),
    .column_o (column),
    .done_o   (win_done)
  );

  // both trees see the same column and stay aligned.
  column_extreme #(
    .FIND_MAX (1'b1)
  ) i_max_tree (
    .clk      (clk),
    .rst_n    (rst_n),
    .column_i (column),
    .done_i   (win_done),
    .result_o (max_res)
  );

  column_extreme #(
    .FIND_MAX (1'b0)
  ) i_min_tree (
    .clk      (clk),
    .rst_n    (rst_n),
    .column_i (column),
    .done_i   (win_done),
    .result_o (min_res)
  );

  range_combiner #(
    .THRESHOLD (THRESHOLD)
  ) i_range_combiner (
    .clk     (clk),
    .rst_n   (rst_n),
    .max_i   (max_res),
    .min_i   (min_res),
    .range_o (range_o),
    .edge_o  (edge_o),
    .done_o  (done_o)
  );

endmodule

// ==== hdl/range_combiner.sv ====
`timescale 1ns/100ps

module range_combiner #(
  parameter int THRESHOLD = contrast_cfg_pkg::THRESHOLD_DEFAULT
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  contrast_types_pkg::extreme_t max_i,
  input  contrast_types_pkg::extreme_t min_i,
  output contrast_types_pkg::range_t   range_o,
  output logic                         edge_o,
  output logic                         done_o
);

  contrast_types_pkg::range_t diff;
  logic                       over;

  // max never below min, so no wrap.
  assign diff = max_i.value - min_i.value;
  assign over = int'(diff) > THRESHOLD;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      range_o <= '0;
      edge_o  <= 1'b0;
      done_o  <= 1'b0;
    end else begin
      range_o <= diff;
      edge_o  <= over;
      done_o  <= max_i.done; // both trees carry the same done.
    end
  end

endmodule

// ==== row_window/line_buffer.sv ====
`timescale 1ns/100ps

module line_buffer #(
  parameter int ROW_LEN = contrast_cfg_pkg::ROW_LEN_DEFAULT
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  contrast_types_pkg::pixel_t  pix_i,
  input  logic                        done_i,
  output contrast_types_pkg::pixel_t  pix_o,
  output logic                        done_o
);

  localparam int IDX_W = (ROW_LEN > 1) ? $clog2(ROW_LEN) : 1;

  typedef struct packed {
    contrast_types_pkg::pixel_t pix;
    logic                       done;
  } entry_t;

  typedef logic [IDX_W-1:0] idx_t;

  entry_t mem [ROW_LEN];
  idx_t   wr_idx;
  entry_t rd_entry;

  // slot under the index was written one row ago.
  assign rd_entry = mem[wr_idx];
  assign pix_o    = rd_entry.pix;
  assign done_o   = rd_entry.done;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_idx <= '0;
      for (int i = 0; i < ROW_LEN; i++) begin
        mem[i] <= '0; // upper taps read zero until filled.
      end
    end else begin
      mem[wr_idx] <= '{pix: pix_i, done: done_i};
      if (wr_idx == idx_t'(ROW_LEN - 1)) begin
        wr_idx <= '0;
      end else begin
        wr_idx <= wr_idx + idx_t'(1);
      end
    end
  end

endmodule

// ==== row_window/row_window.sv ====
`timescale 1ns/100ps

module row_window #(
  parameter int ROW_LEN = contrast_cfg_pkg::ROW_LEN_DEFAULT
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  contrast_types_pkg::pixel_t  pix_i,
  input  logic                        done_i,
  output contrast_types_pkg::column_t column_o,
  output logic                        done_o
);

  localparam int ROWS  = contrast_cfg_pkg::WINDOW_ROWS;
  localparam int CNT_W = contrast_cfg_pkg::STRETCH_CNT_W;

  typedef logic [CNT_W-1:0] cnt_t;

  cnt_t stretch_cnt;
  logic stretch_q;

  // tap[0] is the live pixel, tap[k] comes out of buffer k-1.
  contrast_types_pkg::pixel_t tap [ROWS];
  logic                       done_tap [ROWS];

  // keeps done up for one extra row so the last rows flush.
  // together with done_i the first buffer sees ROW_LEN+1 cycles of done.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      stretch_cnt <= '0;
      stretch_q   <= 1'b0;
    end else if (done_i) begin
      stretch_cnt <= '0; // a new frame end restarts the stretch.
      stretch_q   <= 1'b1;
    end else if (stretch_q && stretch_cnt < cnt_t'(ROW_LEN - 1)) begin
      stretch_cnt <= stretch_cnt + cnt_t'(1);
      stretch_q   <= 1'b1;
    end else begin
      stretch_cnt <= '0;
      stretch_q   <= 1'b0;
    end
  end

  assign tap[0]      = pix_i;
  assign done_tap[0] = done_i | stretch_q;

  for (genvar i = 0; i < ROWS - 1; i++) begin : g_rows
    line_buffer #(
      .ROW_LEN (ROW_LEN)
    ) i_line_buffer (
      .clk    (clk),
      .rst_n  (rst_n),
      .pix_i  (tap[i]),
      .done_i (done_tap[i]),
      .pix_o  (tap[i+1]),
      .done_o (done_tap[i+1])
    );
  end

  always_comb begin
    for (int k = 0; k < ROWS; k++) begin
      column_o[k] = tap[k];
    end
  end

  assign done_o = done_tap[ROWS-1]; // done of the oldest row.

endmodule
